//--- cache_pkg.sv
package cache_pkg;

    // Cache geometry
    localparam int offset_bits = 5;
    localparam int index_bits  = 3;
    localparam int tag_bits    = 24;
    localparam int num_sets    = 8;
    localparam int line_bytes  = 32;

    // Byte address on both the CPU and the memory side
    typedef logic [31:0] addr_t;

    typedef logic [tag_bits-1:0] tag_t;

    typedef logic [index_bits-1:0] index_t;

    // One full cache line
    typedef logic [8*line_bytes-1:0] line_t;

    // One enable bit per byte of a line
    typedef logic [line_bytes-1:0] byte_en_t;

    // CPU request, held stable until cpu_resp
    typedef struct packed {
        logic     read;
        logic     write;
        addr_t    addr;
        line_t    wdata;
        byte_en_t byte_en;
    } cpu_req_t;

    // Memory request, always line aligned
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        line_t wdata;
    } mem_req_t;

endpackage

//--- cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // Source of the data written into a way
    typedef enum logic {
        cpu_wdata,
        mem_rdata
    } datamux_sel_t;

    // Source of the memory address
    typedef enum logic [1:0] {
        cpu_addr,
        way0_addr,
        way1_addr
    } addrmux_sel_t;

    // Controller states
    typedef enum logic [1:0] {
        idle,
        compare,
        write_back,
        allocate
    } ctrl_state_t;

endpackage

//--- cache_array.sv
`timescale 1ns/1ps

// Per-set storage for tags and the single-bit valid, dirty and LRU flags
module cache_array (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load,
    input  cache_pkg::index_t rindex,
    input  cache_pkg::index_t windex,
    input  cache_pkg::tag_t   datain,
    output cache_pkg::tag_t   dataout
);

    cache_pkg::tag_t data [cache_pkg::num_sets];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cache_pkg::num_sets; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[windex] <= datain;
        end
    end

    // Read is combinational so the compare happens in the same cycle
    assign dataout = data[rindex];

endmodule

//--- cache_data_array.sv
`timescale 1ns/1ps

// Line storage, one write enable per byte
module cache_data_array (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::byte_en_t write_en,
    input  cache_pkg::index_t   rindex,
    input  cache_pkg::index_t   windex,
    input  cache_pkg::line_t    datain,
    output cache_pkg::line_t    dataout
);

    cache_pkg::line_t data [cache_pkg::num_sets];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cache_pkg::num_sets; i++) begin
                data[i] <= '0;
            end
        end else begin
            // Merge only the enabled bytes into the stored line
            for (int b = 0; b < cache_pkg::line_bytes; b++) begin
                if (write_en[b]) begin
                    data[windex][8*b +: 8] <= datain[8*b +: 8];
                end
            end
        end
    end

    assign dataout = data[rindex];

endmodule

//--- cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
    input  logic                         clk,
    input  logic                         rst_n,

    // CPU side
    input  cache_pkg::addr_t             cpu_addr,
    input  cache_pkg::line_t             cpu_wdata,
    input  cache_pkg::byte_en_t          cpu_byte_en,
    output cache_pkg::line_t             cpu_rdata,

    // Memory side
    input  cache_pkg::line_t             mem_rdata,
    output cache_pkg::addr_t             mem_addr,
    output cache_pkg::line_t             mem_wdata,

    // Status to the controller
    output logic                         hit,
    output logic                         hit_way,
    output logic                         lru_way,
    output logic                         lru_dirty,

    // Strobes from the controller, one bit per way
    input  logic [1:0]                   load_tag,
    input  logic [1:0]                   set_valid,
    input  logic [1:0]                   load_dirty,
    input  logic [1:0]                   dirty_in,
    input  logic [1:0]                   load_data,
    input  logic                         load_lru,
    input  logic                         lru_in,
    input  cache_ctrl_pkg::datamux_sel_t datamux_sel,
    input  cache_ctrl_pkg::addrmux_sel_t addrmux_sel
);

    cache_pkg::tag_t     tag;
    cache_pkg::index_t   set_index;
    cache_pkg::tag_t     tag_out [2];
    cache_pkg::tag_t     valid_word [2];
    cache_pkg::tag_t     dirty_word [2];
    cache_pkg::tag_t     lru_word;
    cache_pkg::line_t    data_in;
    cache_pkg::line_t    data_out [2];
    cache_pkg::byte_en_t data_write_en [2];
    logic [1:0]          valid_out;
    logic [1:0]          dirty_out;
    logic [1:0]          way_match;

    // Address split
    assign tag       = cpu_addr[31 -: cache_pkg::tag_bits];
    assign set_index = cpu_addr[cache_pkg::offset_bits +: cache_pkg::index_bits];

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_array tag_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (load_tag[w]),
            .rindex  (set_index),
            .windex  (set_index),
            .datain  (tag),
            .dataout (tag_out[w])
        );

        // Valid is only ever set, a line is never invalidated
        cache_array valid_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (set_valid[w]),
            .rindex  (set_index),
            .windex  (set_index),
            .datain  (cache_pkg::tag_t'(1'b1)),
            .dataout (valid_word[w])
        );

        cache_array dirty_array (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (load_dirty[w]),
            .rindex  (set_index),
            .windex  (set_index),
            .datain  (cache_pkg::tag_t'(dirty_in[w])),
            .dataout (dirty_word[w])
        );

        cache_data_array data_array (
            .clk      (clk),
            .rst_n    (rst_n),
            .write_en (data_write_en[w]),
            .rindex   (set_index),
            .windex   (set_index),
            .datain   (data_in),
            .dataout  (data_out[w])
        );

        assign valid_out[w] = valid_word[w][0];
        assign dirty_out[w] = dirty_word[w][0];
    end

    // One LRU bit per set, names the way to evict next
    cache_array lru_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load_lru),
        .rindex  (set_index),
        .windex  (set_index),
        .datain  (cache_pkg::tag_t'(lru_in)),
        .dataout (lru_word)
    );

    always_comb begin
        way_match[0] = valid_out[0] && (tag == tag_out[0]);
        way_match[1] = valid_out[1] && (tag == tag_out[1]);
        hit          = |way_match;
        hit_way      = way_match[1];
        lru_way      = lru_word[0];
        lru_dirty    = dirty_out[lru_way];
    end

    always_comb begin
        // Data-in source
        case (datamux_sel)
            cache_ctrl_pkg::mem_rdata: data_in = mem_rdata;
            default:                   data_in = cpu_wdata;
        endcase

        // Fills write the whole line, CPU writes only their enabled bytes
        for (int w = 0; w < 2; w++) begin
            if (!load_data[w]) begin
                data_write_en[w] = '0;
            end else if (datamux_sel == cache_ctrl_pkg::mem_rdata) begin
                data_write_en[w] = '1;
            end else begin
                data_write_en[w] = cpu_byte_en;
            end
        end

        cpu_rdata = data_out[hit_way];
        mem_wdata = data_out[lru_way];

        // Memory address is always line aligned
        case (addrmux_sel)
            cache_ctrl_pkg::way0_addr:
                mem_addr = {tag_out[0], set_index, {cache_pkg::offset_bits{1'b0}}};
            cache_ctrl_pkg::way1_addr:
                mem_addr = {tag_out[1], set_index, {cache_pkg::offset_bits{1'b0}}};
            default:
                mem_addr = {tag, set_index, {cache_pkg::offset_bits{1'b0}}};
        endcase
    end

    // A fill into a set that already holds the tag would leave two matching ways
    assert property (@(posedge clk) disable iff (!rst_n) !(way_match[0] && way_match[1]))
        else $error("Both ways hit for address %h", cpu_addr);

endmodule

//--- cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic                         clk,
    input  logic                         rst_n,

    // CPU handshake
    input  logic                         read,
    input  logic                         write,
    output logic                         cpu_resp,

    // Datapath status
    input  logic                         hit,
    input  logic                         hit_way,
    input  logic                         lru_way,
    input  logic                         lru_dirty,

    // Memory handshake
    input  logic                         mem_resp,
    output logic                         mem_read,
    output logic                         mem_write,

    // Datapath strobes, one bit per way
    output logic [1:0]                   load_tag,
    output logic [1:0]                   set_valid,
    output logic [1:0]                   load_dirty,
    output logic [1:0]                   dirty_in,
    output logic [1:0]                   load_data,
    output logic                         load_lru,
    output logic                         lru_in,
    output cache_ctrl_pkg::datamux_sel_t datamux_sel,
    output cache_ctrl_pkg::addrmux_sel_t addrmux_sel
);

    cache_ctrl_pkg::ctrl_state_t state_q;
    cache_ctrl_pkg::ctrl_state_t state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cache_ctrl_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        cpu_resp    = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        load_tag    = 2'b00;
        set_valid   = 2'b00;
        load_dirty  = 2'b00;
        dirty_in    = 2'b00;
        load_data   = 2'b00;
        load_lru    = 1'b0;
        lru_in      = 1'b0;
        datamux_sel = cache_ctrl_pkg::cpu_wdata;
        addrmux_sel = cache_ctrl_pkg::cpu_addr;

        case (state_q)
            cache_ctrl_pkg::idle: begin
                if (read || write) begin
                    state_d = cache_ctrl_pkg::compare;
                end
            end

            cache_ctrl_pkg::compare: begin
                if (hit) begin
                    cpu_resp = 1'b1;
                    // Other way becomes the eviction candidate
                    load_lru = 1'b1;
                    lru_in   = ~hit_way;
                    if (write) begin
                        load_data[hit_way]  = 1'b1;
                        load_dirty[hit_way] = 1'b1;
                        dirty_in[hit_way]   = 1'b1;
                    end
                    state_d = cache_ctrl_pkg::idle;
                end else if (lru_dirty) begin
                    state_d = cache_ctrl_pkg::write_back;
                end else begin
                    state_d = cache_ctrl_pkg::allocate;
                end
            end

            cache_ctrl_pkg::write_back: begin
                // Victim address rebuilt from its stored tag
                mem_write   = 1'b1;
                addrmux_sel = lru_way ? cache_ctrl_pkg::way1_addr
                                      : cache_ctrl_pkg::way0_addr;
                if (mem_resp) begin
                    state_d = cache_ctrl_pkg::allocate;
                end
            end

            cache_ctrl_pkg::allocate: begin
                mem_read    = 1'b1;
                datamux_sel = cache_ctrl_pkg::mem_rdata;
                if (mem_resp) begin
                    load_data[lru_way]  = 1'b1;
                    load_tag[lru_way]   = 1'b1;
                    set_valid[lru_way]  = 1'b1;
                    load_dirty[lru_way] = 1'b1;
                    dirty_in[lru_way]   = 1'b0;
                    state_d             = cache_ctrl_pkg::compare;
                end
            end

            default: begin
                state_d = cache_ctrl_pkg::idle;
            end
        endcase
    end

    // Memory answers only a request that is still held
    assert property (@(posedge clk) disable iff (!rst_n) mem_resp |-> (mem_read || mem_write))
        else $error("mem_resp without a pending memory request");

    // Requester holds its request until the response
    assert property (@(posedge clk) disable iff (!rst_n) cpu_resp |-> (read || write))
        else $error("cpu_resp without a pending request");

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::line_t    cpu_rdata,
    output logic                cpu_resp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::line_t    mem_rdata,
    input  logic                mem_resp
);

    logic                         hit;
    logic                         hit_way;
    logic                         lru_way;
    logic                         lru_dirty;
    logic                         mem_read;
    logic                         mem_write;
    logic [1:0]                   load_tag;
    logic [1:0]                   set_valid;
    logic [1:0]                   load_dirty;
    logic [1:0]                   dirty_in;
    logic [1:0]                   load_data;
    logic                         load_lru;
    logic                         lru_in;
    cache_ctrl_pkg::datamux_sel_t datamux_sel;
    cache_ctrl_pkg::addrmux_sel_t addrmux_sel;
    cache_pkg::addr_t             mem_addr;
    cache_pkg::line_t             mem_wdata;

    cache_control control_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .read        (cpu_req.read),
        .write       (cpu_req.write),
        .cpu_resp    (cpu_resp),
        .hit         (hit),
        .hit_way     (hit_way),
        .lru_way     (lru_way),
        .lru_dirty   (lru_dirty),
        .mem_resp    (mem_resp),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .load_tag    (load_tag),
        .set_valid   (set_valid),
        .load_dirty  (load_dirty),
        .dirty_in    (dirty_in),
        .load_data   (load_data),
        .load_lru    (load_lru),
        .lru_in      (lru_in),
        .datamux_sel (datamux_sel),
        .addrmux_sel (addrmux_sel)
    );

    cache_datapath datapath_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_addr    (cpu_req.addr),
        .cpu_wdata   (cpu_req.wdata),
        .cpu_byte_en (cpu_req.byte_en),
        .cpu_rdata   (cpu_rdata),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .hit         (hit),
        .hit_way     (hit_way),
        .lru_way     (lru_way),
        .lru_dirty   (lru_dirty),
        .load_tag    (load_tag),
        .set_valid   (set_valid),
        .load_dirty  (load_dirty),
        .dirty_in    (dirty_in),
        .load_data   (load_data),
        .load_lru    (load_lru),
        .lru_in      (lru_in),
        .datamux_sel (datamux_sel),
        .addrmux_sel (addrmux_sel)
    );

    // Pack the memory request
    assign mem_req = '{read: mem_read, write: mem_write, addr: mem_addr, wdata: mem_wdata};

endmodule

//--- tb_line_memory.sv
`timescale 1ns/1ps

// Behavioural line memory, answers each request after a fixed delay
module tb_line_memory (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::mem_req_t mem_req,
    output cache_pkg::line_t    mem_rdata,
    output logic                mem_resp
);

    localparam int resp_delay = 4;

    // Every write-back in order, also the only record of changed lines
    cache_pkg::addr_t wb_addr_q [$];
    cache_pkg::line_t wb_line_q [$];
    int               wait_count = 0;
    logic             resp_q     = 1'b0;
    cache_pkg::line_t rdata_q    = '0;

    assign mem_resp  = resp_q;
    assign mem_rdata = rdata_q;

    // Latest written copy, or a pattern of word addresses for untouched lines
    function automatic cache_pkg::line_t read_line(input cache_pkg::addr_t addr);
        cache_pkg::line_t line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = (addr + 4 * w) ^ 32'h6b3d_91c5;
        end
        for (int i = 0; i < wb_addr_q.size(); i++) begin
            if (wb_addr_q[i] == addr) begin
                line = wb_line_q[i];
            end
        end
        return line;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_q     <= 1'b0;
            rdata_q    <= '0;
            wait_count <= 0;
        end else if (resp_q) begin
            resp_q     <= 1'b0;
            wait_count <= 0;
        end else if (mem_req.read || mem_req.write) begin
            if (wait_count == resp_delay - 1) begin
                resp_q <= 1'b1;
                if (mem_req.write) begin
                    wb_addr_q.push_back(mem_req.addr);
                    wb_line_q.push_back(mem_req.wdata);
                end else begin
                    rdata_q <= read_line(mem_req.addr);
                end
            end else begin
                wait_count <= wait_count + 1;
            end
        end
    end

endmodule

//--- tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;

    localparam int   num_entries    = 21;
    localparam int   timeout_cycles = num_entries * 20;
    localparam logic op_rd          = 1'b0;
    localparam logic op_wr          = 1'b1;

    // Write flag, address, expected hit, expected write-back
    typedef struct packed {
        logic             is_write;
        cache_pkg::addr_t addr;
        logic             exp_hit;
        logic             exp_wb;
    } stim_t;

    logic                clk;
    logic                rst_n;
    cache_pkg::cpu_req_t cpu_req;
    cache_pkg::line_t    cpu_rdata;
    logic                cpu_resp;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::line_t    mem_rdata;
    logic                mem_resp;

    stim_t       stim_table [num_entries];
    logic [31:0] lfsr        = 32'hb890;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    // Golden memory holds only the lines written back so far
    cache_pkg::addr_t gold_addr_q [$];
    cache_pkg::line_t gold_line_q [$];

    // Golden cache state per set and way
    logic             ref_valid [cache_pkg::num_sets][2];
    logic             ref_dirty [cache_pkg::num_sets][2];
    cache_pkg::tag_t  ref_tag   [cache_pkg::num_sets][2];
    cache_pkg::line_t ref_line  [cache_pkg::num_sets][2];
    logic             ref_lru   [cache_pkg::num_sets];

    // Predictions for the access in flight
    logic             exp_hit;
    logic             exp_wb;
    cache_pkg::addr_t exp_wb_addr;
    cache_pkg::line_t exp_wb_line;
    cache_pkg::line_t exp_rdata;

    cache_top cache_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_rdata (cpu_rdata),
        .cpu_resp  (cpu_resp),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    tb_line_memory mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Galois step, right shifting, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // Memory contents as the test expects them
    function automatic cache_pkg::line_t gold_read(input cache_pkg::addr_t addr);
        cache_pkg::line_t line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = (addr + 4 * w) ^ 32'h6b3d_91c5;
        end
        for (int i = 0; i < gold_addr_q.size(); i++) begin
            if (gold_addr_q[i] == addr) begin
                line = gold_line_q[i];
            end
        end
        return line;
    endfunction

    // One LFSR step per bit of data and byte enable
    task automatic make_write_data();
        for (int i = 0; i < 8 * cache_pkg::line_bytes; i++) begin
            cpu_req.wdata[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        for (int i = 0; i < cache_pkg::line_bytes; i++) begin
            cpu_req.byte_en[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Two-way LRU write-back reference, updated before the DUT runs the access
    task automatic predict_access(input stim_t s);
        cache_pkg::tag_t   tag;
        cache_pkg::index_t idx;
        int                way;

        tag     = s.addr[31:8];
        idx     = s.addr[7:5];
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        way     = ref_lru[idx];
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                exp_hit = 1'b1;
                way     = w;
            end
        end
        if (!exp_hit) begin
            if (ref_valid[idx][way] && ref_dirty[idx][way]) begin
                exp_wb      = 1'b1;
                exp_wb_addr = {ref_tag[idx][way], idx, 5'b0};
                exp_wb_line = ref_line[idx][way];
                gold_addr_q.push_back(exp_wb_addr);
                gold_line_q.push_back(exp_wb_line);
            end
            ref_line[idx][way]  = gold_read({s.addr[31:5], 5'b0});
            ref_tag[idx][way]   = tag;
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
        end
        if (s.is_write) begin
            for (int b = 0; b < cache_pkg::line_bytes; b++) begin
                if (cpu_req.byte_en[b]) begin
                    ref_line[idx][way][8*b +: 8] = cpu_req.wdata[8*b +: 8];
                end
            end
            ref_dirty[idx][way] = 1'b1;
        end
        ref_lru[idx] = (way == 0);
        exp_rdata    = ref_line[idx][way];
    endtask

    task automatic run_access(input int n);
        stim_t            s;
        cache_pkg::addr_t line_addr;
        logic             saw_mem;
        logic             saw_read;
        int               wb_before;

        s               = stim_table[n];
        line_addr       = {s.addr[31:5], 5'b0};
        cpu_req.read    = !s.is_write;
        cpu_req.write   = s.is_write;
        cpu_req.addr    = s.addr;
        cpu_req.wdata   = '0;
        cpu_req.byte_en = '0;
        if (s.is_write) begin
            make_write_data();
        end
        predict_access(s);
        check_count++;
        assert (exp_hit == s.exp_hit && exp_wb == s.exp_wb) else begin
            error_count++;
            $display("Entry %0d: the table flags disagree with the reference model", n);
        end
        wb_before = mem_i.wb_addr_q.size();
        saw_mem   = 1'b0;
        saw_read  = 1'b0;
        do begin
            @(negedge clk);
            if (mem_req.read && !saw_read) begin
                saw_read = 1'b1;
                check_count++;
                assert (mem_req.addr == line_addr) else begin
                    error_count++;
                    $display("[FAIL] mem_req.addr entry %0d: got %h expected %h",
                             n, mem_req.addr, line_addr);
                end
            end
            saw_mem = saw_mem | mem_req.read | mem_req.write;
        end while (!cpu_resp);

        // A hit answers without touching memory
        check_count++;
        assert (!saw_mem == s.exp_hit) else begin
            error_count++;
            $display("[FAIL] hit entry %0d: got %h expected %h", n, !saw_mem, s.exp_hit);
        end
        // A miss must fetch its line
        if (!s.exp_hit) begin
            check_count++;
            assert (saw_read) else begin
                error_count++;
                $display("Entry %0d: the miss finished without a memory read", n);
            end
        end
        if (!s.is_write) begin
            check_count++;
            assert (cpu_rdata == exp_rdata) else begin
                error_count++;
                $display("[FAIL] cpu_rdata entry %0d: got %h expected %h",
                         n, cpu_rdata, exp_rdata);
            end
        end
        @(negedge clk);
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;

        check_count++;
        assert (mem_i.wb_addr_q.size() - wb_before == (s.exp_wb ? 1 : 0)) else begin
            error_count++;
            $display("[FAIL] mem_req.write count entry %0d: got %h expected %h",
                     n, mem_i.wb_addr_q.size() - wb_before, s.exp_wb);
        end
        if (s.exp_wb && mem_i.wb_addr_q.size() > wb_before) begin
            check_count++;
            assert (mem_i.wb_addr_q[wb_before] == exp_wb_addr &&
                    mem_i.wb_line_q[wb_before] == exp_wb_line) else begin
                error_count++;
                $display("[FAIL] mem_req.addr entry %0d: got %h expected %h",
                         n, mem_i.wb_addr_q[wb_before], exp_wb_addr);
                $display("[FAIL] mem_req.wdata entry %0d: got %h expected %h",
                         n, mem_i.wb_line_q[wb_before], exp_wb_line);
            end
        end
    endtask

    task automatic load_table();
        // First touch of every set, some with a byte offset
        stim_table[0]  = {op_rd, 32'h0000_1000, 1'b0, 1'b0};
        stim_table[1]  = {op_rd, 32'h0000_1024, 1'b0, 1'b0};
        stim_table[2]  = {op_rd, 32'h0000_1040, 1'b0, 1'b0};
        stim_table[3]  = {op_rd, 32'h0000_106c, 1'b0, 1'b0};
        stim_table[4]  = {op_rd, 32'h0000_1080, 1'b0, 1'b0};
        stim_table[5]  = {op_rd, 32'h0000_10a0, 1'b0, 1'b0};
        stim_table[6]  = {op_rd, 32'h0000_10c0, 1'b0, 1'b0};
        stim_table[7]  = {op_rd, 32'h0000_10fc, 1'b0, 1'b0};
        // Repeat read, then a merged write and its read back
        stim_table[8]  = {op_rd, 32'h0000_1000, 1'b1, 1'b0};
        stim_table[9]  = {op_wr, 32'h0000_1008, 1'b1, 1'b0};
        stim_table[10] = {op_rd, 32'h0000_1000, 1'b1, 1'b0};
        // Set 2 sees A B A, then C evicts the clean B and A stays
        stim_table[11] = {op_rd, 32'h0000_2040, 1'b0, 1'b0};
        stim_table[12] = {op_rd, 32'h0000_1040, 1'b1, 1'b0};
        stim_table[13] = {op_rd, 32'h0000_3040, 1'b0, 1'b0};
        stim_table[14] = {op_rd, 32'h0000_1040, 1'b1, 1'b0};
        // Set 3 dirty A goes out when C arrives, then comes back merged
        stim_table[15] = {op_wr, 32'h0000_1064, 1'b1, 1'b0};
        stim_table[16] = {op_rd, 32'h0000_2060, 1'b0, 1'b0};
        stim_table[17] = {op_rd, 32'h0000_3060, 1'b0, 1'b1};
        stim_table[18] = {op_rd, 32'h0000_1060, 1'b0, 1'b0};
        // Write miss fills the free way of set 0, then C evicts the dirty line at 1000
        stim_table[19] = {op_wr, 32'h0000_2000, 1'b0, 1'b0};
        stim_table[20] = {op_rd, 32'h0000_3000, 1'b0, 1'b1};
    endtask

    initial begin
        cpu_req = '0;
        rst_n   = 1'b0;
        for (int set_i = 0; set_i < cache_pkg::num_sets; set_i++) begin
            ref_lru[set_i] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_valid[set_i][w] = 1'b0;
                ref_dirty[set_i][w] = 1'b0;
            end
        end
        load_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_count++;
        assert (!cpu_resp && !mem_req.read && !mem_req.write) else begin
            error_count++;
            $display("[FAIL] after reset cpu_resp %h mem_req.read %h mem_req.write %h",
                     cpu_resp, mem_req.read, mem_req.write);
        end

        for (int i = 0; i < num_entries; i++) begin
            run_access(i);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
cache_pkg.sv
cache_ctrl_pkg.sv
cache_array.sv
cache_data_array.sv
cache_datapath.sv
cache_control.sv
cache_top.sv
tb_line_memory.sv
tb_cache_top.sv
